// ==== src/clint_pkg.sv ====
// clint_pkg: bus widths, register map, tick divider, fsm encodings, byte mask helper
package clint_pkg;

  localparam int unsigned DATA_W = 64;
  localparam int unsigned ADDR_W = 64;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned STRB_W = DATA_W / 8;

  // only the low word of msip is implemented
  localparam int unsigned MSIP_W = 32;

  localparam logic [ADDR_W-1:0] MSIP_ADDR     = 64'h0000_0000_0200_0000;
  localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
  localparam logic [ADDR_W-1:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

  // mtime ticks when the prescaler wraps
  localparam int unsigned TICK_DIV_W = 3;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  localparam int unsigned IRQ_W     = 2;
  localparam int unsigned IRQ_SOFT  = 0;
  localparam int unsigned IRQ_TIMER = 1;

  typedef enum logic [0:0] {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // expand byte strobes into a bit mask
  function automatic logic [DATA_W-1:0] strb_to_mask(input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    for (int i = 0; i < STRB_W; i++) begin
      mask[i*8 +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage

// ==== src/clint_reg_if.sv ====
// clint_reg_if: register write and read access from the bus front end to the register block
interface clint_reg_if import clint_pkg::*; ();

  // write side, wr_en is the w handshake
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;

  // read side, combinational return
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  modport bus (
    output wr_en, wr_addr, wr_data, wr_strb,
    output rd_addr,
    input  rd_data
  );

  modport regs (
    input  wr_en, wr_addr, wr_data, wr_strb,
    input  rd_addr,
    output rd_data
  );

endinterface

// ==== src/clint_axi_slave.sv ====
// AXI4 slave read and write fsms, address and id capture, response channels
module clint_axi_slave import clint_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  input  logic              aw_valid_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [ID_W-1:0]   aw_id_i,
  output logic              aw_ready_o,

  input  logic              w_valid_i,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  output logic              w_ready_o,

  input  logic              b_ready_i,
  output logic              b_valid_o,
  output logic [1:0]        b_resp_o,
  output logic [ID_W-1:0]   b_id_o,

  input  logic              ar_valid_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [ID_W-1:0]   ar_id_i,
  output logic              ar_ready_o,

  input  logic              r_ready_i,
  output logic              r_valid_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o,
  output logic [ID_W-1:0]   r_id_o,

  clint_reg_if.bus          reg_if
);

  rd_state_e rd_state;
  wr_state_e wr_state;

  logic [ADDR_W-1:0] rd_addr_q;
  logic [ID_W-1:0]   rd_id_q;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [ID_W-1:0]   wr_id_q;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // read fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (ar_hs) rd_state <= RD_DATA;
        RD_DATA: if (r_hs) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_addr_q <= ar_addr_i;
      rd_id_q   <= ar_id_i;
    end
  end

  assign ar_ready_o = (rd_state == RD_IDLE);
  assign r_valid_o  = (rd_state == RD_DATA);
  assign r_last_o   = r_valid_o;
  assign r_resp_o   = RESP_OKAY;
  assign r_id_o     = rd_id_q;
  // live register value so mtime may move while r is stalled
  assign r_data_o   = reg_if.rd_data;

  // write fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (aw_hs) wr_state <= WR_DATA;
        WR_DATA: if (w_hs && w_last_i) wr_state <= WR_RESP;
        WR_RESP: if (b_hs) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_addr_q <= aw_addr_i;
      wr_id_q   <= aw_id_i;
    end
  end

  assign aw_ready_o = (wr_state == WR_IDLE);
  assign w_ready_o  = (wr_state == WR_DATA);
  assign b_valid_o  = (wr_state == WR_RESP);
  assign b_resp_o   = RESP_OKAY;
  assign b_id_o     = wr_id_q;

  // every beat of a burst hits the captured address
  assign reg_if.wr_en   = w_hs;
  assign reg_if.wr_addr = wr_addr_q;
  assign reg_if.wr_data = w_data_i;
  assign reg_if.wr_strb = w_strb_i;
  assign reg_if.rd_addr = rd_addr_q;

  a_b_valid_held: assert property (
    @(posedge clk) disable iff (rst)
    b_valid_o && !b_ready_i |=> b_valid_o
  ) else $error("b_valid_o dropped before b handshake");

  // leaving idle needs an accepted address
  a_no_w_ready_idle: assert property (
    @(posedge clk) disable iff (rst)
    $rose(w_ready_o) |-> $past(aw_hs)
  ) else $error("w_ready_o rose without an aw handshake");

endmodule

// ==== src/clint_mtime_timer.sv ====
// clint_mtime_timer: tick prescaler and mtime counter with strobed write
module clint_mtime_timer import clint_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  input  logic              mtime_wr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic [STRB_W-1:0] wr_strb_i,

  output logic [DATA_W-1:0] mtime_o
);

  logic [TICK_DIV_W-1:0] prescale_q;
  logic                  tick;
  logic [DATA_W-1:0]     mtime_q;
  logic [DATA_W-1:0]     wr_mask;

  // free running divider
  always_ff @(posedge clk) begin
    if (rst) begin
      prescale_q <= '0;
    end else begin
      prescale_q <= prescale_q + 1'b1;
    end
  end

  assign tick    = &prescale_q;
  assign wr_mask = strb_to_mask(wr_strb_i);

  // a bus write wins over the tick
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (mtime_wr_i) begin
      mtime_q <= (mtime_q & ~wr_mask) | (wr_data_i & wr_mask);
    end else if (tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  assign mtime_o = mtime_q;

endmodule

// ==== src/clint_regs.sv ====
// clint_regs: address decode, msip and mtimecmp, read mux, interrupt lines
module clint_regs import clint_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  clint_reg_if.regs         reg_if,

  input  logic [DATA_W-1:0] mtime_i,

  output logic              mtime_wr_o,
  output logic [DATA_W-1:0] mtime_wdata_o,
  output logic [STRB_W-1:0] mtime_wstrb_o,

  output logic [IRQ_W-1:0]  irq_o
);

  logic [MSIP_W-1:0] msip_q;
  logic [DATA_W-1:0] mtimecmp_q;
  logic [DATA_W-1:0] wr_mask;

  logic msip_sel;
  logic mtimecmp_sel;
  logic mtime_sel;

  // write decode
  assign msip_sel     = (reg_if.wr_addr == MSIP_ADDR);
  assign mtimecmp_sel = (reg_if.wr_addr == MTIMECMP_ADDR);
  assign mtime_sel    = (reg_if.wr_addr == MTIME_ADDR);

  assign wr_mask = strb_to_mask(reg_if.wr_strb);

  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= '0;
    end else if (reg_if.wr_en && msip_sel) begin
      msip_q <= (msip_q & ~wr_mask[MSIP_W-1:0]) |
                (reg_if.wr_data[MSIP_W-1:0] & wr_mask[MSIP_W-1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= '0;
    end else if (reg_if.wr_en && mtimecmp_sel) begin
      mtimecmp_q <= (mtimecmp_q & ~wr_mask) | (reg_if.wr_data & wr_mask);
    end
  end

  // mtime itself lives in the timer
  assign mtime_wr_o    = reg_if.wr_en && mtime_sel;
  assign mtime_wdata_o = reg_if.wr_data;
  assign mtime_wstrb_o = reg_if.wr_strb;

  // read mux, unmapped reads as zero
  always_comb begin
    case (reg_if.rd_addr)
      MSIP_ADDR:     reg_if.rd_data = {{(DATA_W-MSIP_W){1'b0}}, msip_q};
      MTIMECMP_ADDR: reg_if.rd_data = mtimecmp_q;
      MTIME_ADDR:    reg_if.rd_data = mtime_i;
      default:       reg_if.rd_data = '0;
    endcase
  end

  assign irq_o[IRQ_SOFT]  = msip_q[0];
  assign irq_o[IRQ_TIMER] = (mtime_i >= mtimecmp_q);

  a_decode_onehot: assert property (
    @(posedge clk) disable iff (rst)
    reg_if.wr_en |-> $onehot0({msip_sel, mtimecmp_sel, mtime_sel})
  ) else $error("more than one register decode active");

endmodule

// ==== src/clint_top.sv ====
// clint_top: CLINT top level with plain AXI4 ports and interrupt outputs
module clint_top import clint_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  input  logic              aw_valid_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [ID_W-1:0]   aw_id_i,
  output logic              aw_ready_o,

  input  logic              w_valid_i,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  output logic              w_ready_o,

  input  logic              b_ready_i,
  output logic              b_valid_o,
  output logic [1:0]        b_resp_o,
  output logic [ID_W-1:0]   b_id_o,

  input  logic              ar_valid_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [ID_W-1:0]   ar_id_i,
  output logic              ar_ready_o,

  input  logic              r_ready_i,
  output logic              r_valid_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o,
  output logic [ID_W-1:0]   r_id_o,

  output logic [IRQ_W-1:0]  irq_o
);

  clint_reg_if reg_if ();

  logic              mtime_wr;
  logic [DATA_W-1:0] mtime_wdata;
  logic [STRB_W-1:0] mtime_wstrb;
  logic [DATA_W-1:0] mtime;

  clint_axi_slave u_axi_slave (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .w_ready_o  (w_ready_o),
    .b_ready_i  (b_ready_i),
    .b_valid_o  (b_valid_o),
    .b_resp_o   (b_resp_o),
    .b_id_o     (b_id_o),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .ar_ready_o (ar_ready_o),
    .r_ready_i  (r_ready_i),
    .r_valid_o  (r_valid_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .r_id_o     (r_id_o),
    .reg_if     (reg_if.bus)
  );

  clint_regs u_regs (
    .clk           (clk),
    .rst           (rst),
    .reg_if        (reg_if.regs),
    .mtime_i       (mtime),
    .mtime_wr_o    (mtime_wr),
    .mtime_wdata_o (mtime_wdata),
    .mtime_wstrb_o (mtime_wstrb),
    .irq_o         (irq_o)
  );

  clint_mtime_timer u_mtime_timer (
    .clk        (clk),
    .rst        (rst),
    .mtime_wr_i (mtime_wr),
    .wr_data_i  (mtime_wdata),
    .wr_strb_i  (mtime_wstrb),
    .mtime_o    (mtime)
  );

endmodule

// ==== verif/tb_clint.sv ====
// tb_clint: clock and reset, AXI driver tasks, xorshift, reference model, checks
module tb_clint import clint_pkg::*; ();

  logic              clk;
  logic              rst;
  logic              aw_valid_i;
  logic [ADDR_W-1:0] aw_addr_i;
  logic [ID_W-1:0]   aw_id_i;
  logic              aw_ready_o;
  logic              w_valid_i;
  logic [DATA_W-1:0] w_data_i;
  logic [STRB_W-1:0] w_strb_i;
  logic              w_last_i;
  logic              w_ready_o;
  logic              b_ready_i;
  logic              b_valid_o;
  logic [1:0]        b_resp_o;
  logic [ID_W-1:0]   b_id_o;
  logic              ar_valid_i;
  logic [ADDR_W-1:0] ar_addr_i;
  logic [ID_W-1:0]   ar_id_i;
  logic              ar_ready_o;
  logic              r_ready_i;
  logic              r_valid_o;
  logic [DATA_W-1:0] r_data_o;
  logic [1:0]        r_resp_o;
  logic              r_last_o;
  logic [ID_W-1:0]   r_id_o;
  logic [IRQ_W-1:0]  irq_o;

  logic [31:0]       rng_state;
  logic [MSIP_W-1:0] model_msip;
  logic [DATA_W-1:0] model_mtimecmp;
  logic [DATA_W-1:0] beat_data [4];
  logic [STRB_W-1:0] beat_strb [4];
  logic [DATA_W-1:0] rd_expected;
  logic              rd_expect_on;
  longint unsigned   cycle;
  longint unsigned   w_cycle;
  int                errors;
  int                errors_at_start;
  int                tests_ok;
  int                tests_bad;

  clint_top UUT (.*);

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
      input logic [DATA_W-1:0] new_val, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res;
  endfunction

  // expected read data, mtime is not modelled
  function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
    if (addr == MSIP_ADDR) return {{(DATA_W-MSIP_W){1'b0}}, model_msip};
    else if (addr == MTIMECMP_ADDR) return model_mtimecmp;
    else return '0;
  endfunction

  function automatic logic [IRQ_W-1:0] ref_irq(input logic [DATA_W-1:0] mtime_now);
    logic [IRQ_W-1:0] irq;
    irq[IRQ_SOFT]  = model_msip[0];
    irq[IRQ_TIMER] = (mtime_now >= model_mtimecmp);
    return irq;
  endfunction

  task automatic check_eq(input string name, input logic [DATA_W-1:0] got,
      input logic [DATA_W-1:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // 0 aw_ready, 1 w_ready, 2 b_valid, 3 ar_ready, 4 r_valid
  function automatic logic chan_level(input int sel);
    case (sel)
      0: return aw_ready_o;
      1: return w_ready_o;
      2: return b_valid_o;
      3: return ar_ready_o;
      default: return r_valid_o;
    endcase
  endfunction

  // returns on the falling edge where the signal is seen high
  task automatic wait_for(input int sel, input string name);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (chan_level(sel) !== 1'b1 && cnt < 100) begin
      @(negedge clk);
      cnt++;
    end
    if (chan_level(sel) !== 1'b1) begin
      $display("timeout: %s did not go high within 100 cycles", name);
      $display("TESTBENCH FAILED");
      $finish;
    end
  endtask

  task automatic fill_beat(input int i);
    logic [31:0] rnd;
    beat_data[i] = {xorshift(), xorshift()};
    rnd = xorshift();
    beat_strb[i] = rnd[STRB_W-1:0];
  endtask

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input int beats);
    logic [31:0]       rnd;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] merged;
    int                i;
    rnd = xorshift();
    id  = rnd[ID_W-1:0];
    @(posedge clk);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    wait_for(0, "aw_ready_o");
    @(posedge clk);
    aw_valid_i <= 1'b0;
    for (i = 0; i < beats; i++) begin
      w_valid_i <= 1'b1;
      w_data_i  <= beat_data[i];
      w_strb_i  <= beat_strb[i];
      w_last_i  <= (i == beats - 1);
      wait_for(1, "w_ready_o");
      @(posedge clk);
      // beat lands on this edge
      w_cycle = cycle;
      if (addr == MSIP_ADDR) begin
        merged = merge_bytes({{(DATA_W-MSIP_W){1'b0}}, model_msip}, beat_data[i], beat_strb[i]);
        model_msip = merged[MSIP_W-1:0];
      end else if (addr == MTIMECMP_ADDR) begin
        model_mtimecmp = merge_bytes(model_mtimecmp, beat_data[i], beat_strb[i]);
      end
    end
    w_valid_i <= 1'b0;
    w_last_i  <= 1'b0;
    rnd = xorshift();
    repeat (rnd % 4) @(posedge clk);
    b_ready_i <= 1'b1;
    wait_for(2, "b_valid_o");
    check_eq("b_id_o", b_id_o, id);
    check_eq("b_resp_o", b_resp_o, 2'b00);
    @(posedge clk);
    b_ready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, input logic check,
      output logic [DATA_W-1:0] data);
    logic [31:0]     rnd;
    logic [ID_W-1:0] id;
    rnd = xorshift();
    id  = rnd[ID_W-1:0];
    rd_expected  = ref_read(addr);
    rd_expect_on = check;
    @(posedge clk);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    wait_for(3, "ar_ready_o");
    @(posedge clk);
    ar_valid_i <= 1'b0;
    rnd = xorshift();
    repeat (rnd % 4) @(posedge clk);
    r_ready_i <= 1'b1;
    wait_for(4, "r_valid_o");
    data = r_data_o;
    check_eq("r_id_o", r_id_o, id);
    check_eq("r_resp_o", r_resp_o, 2'b00);
    check_eq("r_last_o", r_last_o, 1'b1);
    @(posedge clk);
    r_ready_i    <= 1'b0;
    rd_expect_on = 1'b0;
  endtask

  task automatic report_test(input string name);
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_at_start);
      tests_bad++;
    end
    errors_at_start = errors;
  endtask

  // read data and soft interrupt against the model
  always @(negedge clk) begin : compare
    logic [IRQ_W-1:0] irq_exp;
    irq_exp = ref_irq('0);
    if (!rst) begin
      check_eq("irq_o[IRQ_SOFT]", irq_o[IRQ_SOFT], irq_exp[IRQ_SOFT]);
      if (rd_expect_on && r_valid_o && r_ready_i) begin
        check_eq("r_data_o", r_data_o, rd_expected);
      end
    end
  end

  initial begin : main
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] rd2;
    logic [DATA_W-1:0] v;
    logic [IRQ_W-1:0]  irq_exp;
    longint unsigned   k;
    int                n;
    int                cnt;
    clk = 1'b0;
    rst = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_id_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    b_ready_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    ar_id_i = '0;
    r_ready_i = 1'b0;
    rng_state = 32'hfc4d0645;
    model_msip = '0;
    model_mtimecmp = '0;
    rd_expected = '0;
    rd_expect_on = 1'b0;
    cycle = 0;
    w_cycle = 0;
    errors = 0;
    errors_at_start = 0;
    tests_ok = 0;
    tests_bad = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_eq("aw_ready_o", aw_ready_o, 1'b1);
    check_eq("ar_ready_o", ar_ready_o, 1'b1);
    check_eq("w_ready_o", w_ready_o, 1'b0);
    check_eq("b_valid_o", b_valid_o, 1'b0);
    check_eq("r_valid_o", r_valid_o, 1'b0);
    irq_exp = ref_irq('0);
    check_eq("irq_o", irq_o, irq_exp);
    report_test("reset state");

    for (n = 0; n < 4; n++) begin
      fill_beat(0);
      axi_write(MSIP_ADDR, 1);
      axi_read(MSIP_ADDR, 1'b1, rd);
      fill_beat(0);
      axi_write(MTIMECMP_ADDR, 1);
      axi_read(MTIMECMP_ADDR, 1'b1, rd);
    end
    for (n = 0; n < 3; n++) fill_beat(n);
    axi_write(MTIMECMP_ADDR, 3);
    axi_read(MTIMECMP_ADDR, 1'b1, rd);
    report_test("msip and mtimecmp writes");

    beat_data[0] = 64'h1;
    beat_strb[0] = 8'h01;
    axi_write(MSIP_ADDR, 1);
    @(negedge clk);
    check_eq("irq_o[IRQ_SOFT]", irq_o[IRQ_SOFT], 1'b1);
    beat_data[0] = '0;
    axi_write(MSIP_ADDR, 1);
    @(negedge clk);
    check_eq("irq_o[IRQ_SOFT]", irq_o[IRQ_SOFT], 1'b0);
    report_test("software interrupt");

    for (n = 0; n < 3; n++) begin
      v = {xorshift(), xorshift()};
      // headroom so the bound cannot wrap
      v[63:62] = 2'b00;
      beat_data[0] = v;
      beat_strb[0] = '1;
      axi_write(MTIME_ADDR, 1);
      repeat (xorshift() % 24) @(posedge clk);
      axi_read(MTIME_ADDR, 1'b0, rd);
      k = cycle - w_cycle;
      assert (rd >= v && rd <= v + k / 8 + 1) else begin
        $display("FAILED r_data_o: mtime %h outside %h to %h", rd, v, v + k / 8 + 1);
        errors++;
      end
      axi_read(MTIME_ADDR, 1'b0, rd2);
      assert (rd2 >= rd) else begin
        $display("FAILED r_data_o: mtime went back from %h to %h", rd, rd2);
        errors++;
      end
    end
    report_test("mtime behavior");

    beat_data[0] = '1;
    beat_strb[0] = '1;
    axi_write(MTIMECMP_ADDR, 1);
    irq_exp = ref_irq(rd2);
    for (n = 0; n < 32; n++) begin
      @(negedge clk);
      check_eq("irq_o[IRQ_TIMER]", irq_o[IRQ_TIMER], irq_exp[IRQ_TIMER]);
    end
    axi_read(MTIME_ADDR, 1'b0, rd);
    beat_data[0] = rd + 4;
    axi_write(MTIMECMP_ADDR, 1);
    cnt = 0;
    @(negedge clk);
    while (irq_o[IRQ_TIMER] !== 1'b1 && cnt < 64) begin
      @(negedge clk);
      cnt++;
    end
    assert (irq_o[IRQ_TIMER] === 1'b1) else begin
      $display("timer interrupt did not rise within 64 cycles");
      errors++;
    end
    for (n = 0; n < 16; n++) begin
      @(negedge clk);
      check_eq("irq_o[IRQ_TIMER]", irq_o[IRQ_TIMER], 1'b1);
    end
    report_test("timer interrupt");

    axi_read(64'h0000_0000_0200_1000, 1'b1, rd);
    fill_beat(0);
    beat_strb[0] = '1;
    axi_write(64'h0000_0000_0200_1000, 1);
    axi_read(64'h0000_0000_0200_1000, 1'b1, rd);
    axi_read(MSIP_ADDR, 1'b1, rd);
    axi_read(MTIMECMP_ADDR, 1'b1, rd);
    report_test("unmapped addresses");

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/clint_pkg.sv
src/clint_reg_if.sv
src/clint_axi_slave.sv
src/clint_mtime_timer.sv
src/clint_regs.sv
src/clint_top.sv
verif/tb_clint.sv

// ==== Bender.yml ====
package:
  name: clint

sources:
  - src/clint_pkg.sv
  - src/clint_reg_if.sv
  - src/clint_axi_slave.sv
  - src/clint_mtime_timer.sv
  - src/clint_regs.sv
  - src/clint_top.sv
  - target: test
    files:
      - verif/tb_clint.sv
